//--- hdl/pe_settings.svh
`ifndef PE_SETTINGS_SVH
`define PE_SETTINGS_SVH

// weight and pixel value width
`define PE_WORD_W 8

// column and row coordinate width
`define PE_COORD_W 8

// job counters
`define PE_COUNT_W 16

// weight slots, window depth and pixels per group
`define PE_LANES 4

`endif

//--- hdl/pe_pkg.sv
`default_nettype none

`include "pe_settings.svh"

package pe_pkg;

    typedef logic signed [`PE_WORD_W-1:0]   word_t;
    typedef logic signed [2*`PE_WORD_W-1:0] product_t;
    typedef logic signed [`PE_COORD_W-1:0]  coord_t;
    typedef logic [`PE_COUNT_W-1:0]         count_t;
    typedef logic [1:0]                     slot_t;

    // one kernel entry
    typedef struct packed {
        word_t  value;
        coord_t col;
        coord_t row;
    } weight_entry_t;

    // lane 0 sits in the low bits of each field
    typedef struct packed {
        word_t  [`PE_LANES-1:0] value;
        coord_t [`PE_LANES-1:0] col;
        coord_t [`PE_LANES-1:0] row;
    } feature_group_t;

    // element index is slot*lanes + lane
    typedef struct packed {
        product_t [`PE_LANES*`PE_LANES-1:0] product;
        coord_t   [`PE_LANES*`PE_LANES-1:0] col_off;
        coord_t   [`PE_LANES*`PE_LANES-1:0] row_off;
    } pe_result_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_WEIGHT,
        LOAD_FEATURE,
        DONE
    } pe_state_e;

endpackage

`default_nettype wire

//--- hdl/pe_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_settings.svh"

module pe_sequencer
    import pe_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   in_valid,
    input  count_t weight_count,
    input  count_t feature_count,
    output logic   weight_we,
    output slot_t  weight_slot,
    output logic   feature_shift,
    output logic   out_valid
);

    pe_state_e state;
    pe_state_e next_state;
    count_t    cycle_cnt;
    count_t    next_cycle_cnt;
    count_t    weight_cnt;
    count_t    next_weight_cnt;
    logic      accept;
    logic      pass_end;

    // idle only accepts on in_valid, both load states always do
    assign accept = (state == IDLE && in_valid) ||
                    state == LOAD_WEIGHT ||
                    state == LOAD_FEATURE;

    // cycle_cnt is k-1 for pass cycle k
    assign pass_end = accept && (cycle_cnt == feature_count - count_t'(1));

    // first four cycles of a pass fill the slots in order
    assign weight_we     = accept && (cycle_cnt < count_t'(`PE_LANES));
    assign weight_slot   = slot_t'(cycle_cnt);
    assign feature_shift = accept;

    assign next_weight_cnt = weight_we ? weight_cnt + count_t'(1) : weight_cnt;

    always_comb begin
        next_state     = state;
        next_cycle_cnt = cycle_cnt;
        if (accept) begin
            if (pass_end) begin
                next_cycle_cnt = '0;
                // all entries taken, job is over
                if (next_weight_cnt >= weight_count) begin
                    next_state = DONE;
                end else begin
                    next_state = LOAD_WEIGHT;
                end
            end else begin
                next_cycle_cnt = cycle_cnt + count_t'(1);
                if (next_cycle_cnt < count_t'(`PE_LANES)) begin
                    next_state = LOAD_WEIGHT;
                end else begin
                    next_state = LOAD_FEATURE;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            cycle_cnt  <= '0;
            weight_cnt <= '0;
            out_valid  <= 1'b0;
        end else begin
            state      <= next_state;
            cycle_cnt  <= next_cycle_cnt;
            weight_cnt <= next_weight_cnt;
            // result is ready one edge after the data went in
            out_valid  <= feature_shift;
        end
    end

    // no output after a cycle that took nothing
    a_no_spurious_valid: assert property (
        @(posedge clk) disable iff (rst)
        ((state == IDLE && !in_valid) || state == DONE) |=> !out_valid
    );

    a_we_with_shift: assert property (
        @(posedge clk) disable iff (rst)
        weight_we |-> feature_shift
    );

    // job parameters sampled at start
    a_job_counts: assert property (
        @(posedge clk) disable iff (rst)
        (state == IDLE && in_valid) |->
            (feature_count >= count_t'(`PE_LANES)) &&
            (weight_count != '0) &&
            (weight_count % count_t'(`PE_LANES) == '0)
    );

endmodule

`default_nettype wire

//--- hdl/weight_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_settings.svh"

module weight_buffer
    import pe_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          weight_we,
    input  slot_t                         weight_slot,
    input  weight_entry_t                 weight_in,
    output weight_entry_t [`PE_LANES-1:0] weights
);

    weight_entry_t [`PE_LANES-1:0] slots;

    // slots not addressed this pass keep the previous kernel entries
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slots <= '0;
        end else if (weight_we) begin
            slots[weight_slot] <= weight_in;
        end
    end

    assign weights = slots;

    // written entry must be known
    a_weight_known: assert property (
        @(posedge clk) disable iff (rst)
        weight_we |-> !$isunknown(weight_in)
    );

endmodule

`default_nettype wire

//--- hdl/feature_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_settings.svh"

module feature_window
    import pe_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           feature_shift,
    input  feature_group_t                 feature_in,
    output feature_group_t [`PE_LANES-1:0] window
);

    feature_group_t [`PE_LANES-1:0] stages;

    // new group at depth 0, oldest one drops out
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stages <= '0;
        end else if (feature_shift) begin
            stages <= {stages[`PE_LANES-2:0], feature_in};
        end
    end

    assign window = stages;

    a_feature_known: assert property (
        @(posedge clk) disable iff (rst)
        feature_shift |-> !$isunknown(feature_in)
    );

endmodule

`default_nettype wire

//--- hdl/outer_product_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_settings.svh"

module outer_product_array
    import pe_pkg::*;
(
    input  logic                           out_valid,
    input  weight_entry_t [`PE_LANES-1:0]  weights,
    input  feature_group_t [`PE_LANES-1:0] window,
    output pe_result_t                     result
);

    // slot i pairs with window depth i
    always_comb begin
        result = '0;
        if (out_valid) begin
            for (int i = 0; i < `PE_LANES; i++) begin
                for (int j = 0; j < `PE_LANES; j++) begin
                    result.product[i*`PE_LANES+j] =
                        product_t'($signed(weights[i].value)) *
                        product_t'($signed(window[i].value[j]));
                    // offsets wrap at coordinate width
                    result.col_off[i*`PE_LANES+j] = window[i].col[j] - weights[i].col;
                    result.row_off[i*`PE_LANES+j] = window[i].row[j] - weights[i].row;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/pe_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_settings.svh"

module pe_unit
    import pe_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  count_t         weight_count,
    input  count_t         feature_count,
    input  weight_entry_t  weight_in,
    input  feature_group_t feature_in,
    output logic           out_valid,
    output pe_result_t     result
);

    logic                           weight_we;
    slot_t                          weight_slot;
    logic                           feature_shift;
    weight_entry_t [`PE_LANES-1:0]  weights;
    feature_group_t [`PE_LANES-1:0] window;

    pe_sequencer u_sequencer (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .weight_count  (weight_count),
        .feature_count (feature_count),
        .weight_we     (weight_we),
        .weight_slot   (weight_slot),
        .feature_shift (feature_shift),
        .out_valid     (out_valid)
    );

    weight_buffer u_weight_buffer (
        .clk         (clk),
        .rst         (rst),
        .weight_we   (weight_we),
        .weight_slot (weight_slot),
        .weight_in   (weight_in),
        .weights     (weights)
    );

    feature_window u_feature_window (
        .clk           (clk),
        .rst           (rst),
        .feature_shift (feature_shift),
        .feature_in    (feature_in),
        .window        (window)
    );

    outer_product_array u_outer_product_array (
        .out_valid (out_valid),
        .weights   (weights),
        .window    (window),
        .result    (result)
    );

endmodule

`default_nettype wire

//--- bench/pe_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_settings.svh"

module pe_unit_tb
    import pe_pkg::*;
();

    logic           clk;
    logic           rst;
    logic           in_valid;
    count_t         weight_count;
    count_t         feature_count;
    weight_entry_t  weight_in;
    feature_group_t feature_in;
    logic           out_valid;
    pe_result_t     result;

    // reference model of slots, window and job progress
    weight_entry_t [`PE_LANES-1:0]  ref_slots;
    feature_group_t [`PE_LANES-1:0] ref_window;
    logic                           ref_valid;
    logic                           ref_busy;
    logic                           ref_done;
    int                             ref_k;
    int                             ref_pass;
    int                             ref_passes;

    // out_valid the data file expects in the current cycle
    logic exp_file;

    pe_unit dut0 (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .weight_count  (weight_count),
        .feature_count (feature_count),
        .weight_in     (weight_in),
        .feature_in    (feature_in),
        .out_valid     (out_valid),
        .result        (result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic clear_model();
        ref_slots  = '0;
        ref_window = '0;
        ref_valid  = 1'b0;
        ref_busy   = 1'b0;
        ref_done   = 1'b0;
        ref_k      = 0;
        ref_pass   = 0;
        ref_passes = 0;
    endtask

    // applies the accepting cycle rules for the edge that ends this cycle
    task automatic advance_model();
        logic accept;
        accept = ref_busy || (!ref_busy && !ref_done && in_valid);
        if (accept && !ref_busy) begin
            ref_busy   = 1'b1;
            ref_pass   = 1;
            ref_k      = 1;
            ref_passes = int'(weight_count) / `PE_LANES;
        end
        if (accept) begin
            if (ref_k <= `PE_LANES) begin
                ref_slots[slot_t'(ref_k - 1)] = weight_in;
            end
            ref_window = {ref_window[`PE_LANES-2:0], feature_in};
            if (ref_k == int'(feature_count)) begin
                if (ref_pass == ref_passes) begin
                    ref_busy = 1'b0;
                    ref_done = 1'b1;
                end else begin
                    ref_pass = ref_pass + 1;
                    ref_k    = 1;
                end
            end else begin
                ref_k = ref_k + 1;
            end
        end
        ref_valid = accept;
    endtask

    task automatic check_outputs();
        logic [3:0] idx;
        int         prod;
        int         diff;
        product_t   exp_prod;
        coord_t     exp_col;
        coord_t     exp_row;
        assert (out_valid == ref_valid) else
            abort_run($sformatf("error out_valid got %h expected %h", out_valid, ref_valid));
        assert (out_valid == exp_file) else
            abort_run($sformatf("error out_valid got %h expected %h by the data file",
                                out_valid, exp_file));
        for (int i = 0; i < `PE_LANES; i++) begin
            for (int j = 0; j < `PE_LANES; j++) begin
                idx      = 4'(i * `PE_LANES + j);
                exp_prod = '0;
                exp_col  = '0;
                exp_row  = '0;
                if (ref_valid) begin
                    // slot i meets the group at window depth i
                    prod = int'($signed(ref_slots[slot_t'(i)].value)) *
                           int'($signed(ref_window[slot_t'(i)].value[slot_t'(j)]));
                    exp_prod = prod[2*`PE_WORD_W-1:0];
                    diff = int'(ref_window[slot_t'(i)].col[slot_t'(j)]) -
                           int'(ref_slots[slot_t'(i)].col);
                    exp_col = diff[`PE_COORD_W-1:0];
                    diff = int'(ref_window[slot_t'(i)].row[slot_t'(j)]) -
                           int'(ref_slots[slot_t'(i)].row);
                    exp_row = diff[`PE_COORD_W-1:0];
                end
                assert (result.product[idx] == exp_prod) else
                    abort_run($sformatf("error result.product[%0d] got %h expected %h",
                                        idx, result.product[idx], exp_prod));
                assert (result.col_off[idx] == exp_col) else
                    abort_run($sformatf("error result.col_off[%0d] got %h expected %h",
                                        idx, result.col_off[idx], exp_col));
                assert (result.row_off[idx] == exp_row) else
                    abort_run($sformatf("error result.row_off[%0d] got %h expected %h",
                                        idx, result.row_off[idx], exp_row));
            end
        end
    endtask

    // drive on the rising edge, check at the falling edge
    task automatic run_cycle(input logic r, input logic v, input count_t wc,
                             input count_t fc, input weight_entry_t w,
                             input feature_group_t f, input logic exp_next);
        @(posedge clk);
        rst           <= r;
        in_valid      <= v;
        weight_count  <= wc;
        feature_count <= fc;
        weight_in     <= w;
        feature_in    <= f;
        @(negedge clk);
        if (rst) begin
            clear_model();
        end
        check_outputs();
        if (!rst) begin
            advance_model();
        end
        exp_file = exp_next;
    endtask

    initial begin
        int          fd;
        int          n;
        int          line_no;
        int          low_run;
        int          drain;
        string       line;
        logic [31:0] f_rst;
        logic [31:0] f_valid;
        logic [31:0] f_wcnt;
        logic [31:0] f_fcnt;
        logic [31:0] f_w;
        logic [31:0] f_fv;
        logic [31:0] f_fc;
        logic [31:0] f_fr;
        logic [31:0] f_exp;
        rst           = 1'b1;
        in_valid      = 1'b0;
        weight_count  = '0;
        feature_count = '0;
        weight_in     = '0;
        feature_in    = '0;
        exp_file      = 1'b0;
        clear_model();
        repeat (5) run_cycle(1'b1, 1'b0, '0, '0, '0, '0, 1'b0);

        fd = $fopen("bench/pe_unit_input.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file bench/pe_unit_input.txt");
        end else begin
            line_no = 0;
            while (!$feof(fd)) begin
                line    = "";
                n       = $fgets(line, fd);
                line_no = line_no + 1;
                // lines starting with # are comments
                if (n > 0 && line.getc(0) != 8'h23) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_rst, f_valid,
                                f_wcnt, f_fcnt, f_w, f_fv, f_fc, f_fr, f_exp);
                    if (n == 9) begin
                        run_cycle(f_rst[0], f_valid[0], f_wcnt[`PE_COUNT_W-1:0],
                                  f_fcnt[`PE_COUNT_W-1:0], f_w[23:0],
                                  {f_fv, f_fc, f_fr}, f_exp[0]);
                    end else if (n > 0) begin
                        abort_run($sformatf("stimulus line %0d has %0d fields instead of 9",
                                            line_no, n));
                    end
                end
            end
            $fclose(fd);

            // let the DUT settle with no new job
            low_run = 0;
            drain   = 0;
            while (low_run < 4 && drain < 64) begin
                run_cycle(1'b0, 1'b0, weight_count, feature_count, '0, '0, 1'b0);
                drain   = drain + 1;
                low_run = out_valid ? 0 : low_run + 1;
            end
            if (low_run < 4) begin
                abort_run("out_valid did not stay low within 64 cycles after the last line");
            end else begin
                $display("Finished with no errors");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/pe_unit_input.txt
# rst in_valid weight_count feature_count weight(value col row) feature values cols rows
# feature fields list lane 3 first, last column is out_valid expected in the next cycle
# job 1, 8 weights, 5 groups per pass
0 0 8 5 000000 00000000 00000000 00000000 0
0 0 8 5 000000 00000000 00000000 00000000 0
0 0 8 5 000000 00000000 00000000 00000000 0
0 1 8 5 050101 01FF7F80 7F800102 00FE7F81 1
0 0 8 5 FD0200 10F00305 03040506 80807F7F 1
0 0 8 5 7F0003 7F7F8080 FF00FF00 01020304 1
0 0 8 5 80FF02 0102FEFD 10203040 50607080 1
0 0 8 5 111111 C0407F01 81828384 7E7D7C7B 1
0 1 8 5 020304 0A0B0C0D 11223344 55667788 1
0 0 8 5 F010FE F1F2F3F4 99AABBCC DDEEFF00 1
0 0 8 5 09817F 80017F02 0102FEFF 7F80817E 1
0 0 8 5 C30505 03040506 08090A0B 0C0D0E0F 1
0 0 8 5 222222 FEFFFF01 40C040C0 C040C040 1
0 0 8 5 000000 00000000 00000000 00000000 0
0 1 8 5 333333 12121212 34343434 56565656 0
0 1 8 5 444444 78787878 9A9A9A9A BCBCBCBC 0
0 0 8 5 000000 00000000 00000000 00000000 0
0 1 8 5 555555 DEDEDEDE F0F0F0F0 0F0F0F0F 0
# reset between the jobs
1 0 8 5 000000 00000000 00000000 00000000 0
1 0 4 4 000000 00000000 00000000 00000000 0
# job 2, 4 weights, 4 groups per pass
0 0 4 4 000000 00000000 00000000 00000000 0
0 0 4 4 000000 00000000 00000000 00000000 0
0 1 4 4 040202 12345678 01020304 F0F1F2F3 1
0 0 4 4 FF7F80 87654321 A0B0C0D0 0F0E0D0C 1
0 0 4 4 81807F 80808080 7F7F7F7F 80808080 1
0 0 4 4 7E0000 7F7F7F7F 80808080 7F7F7F7F 1
0 0 4 4 000000 00000000 00000000 00000000 0
0 1 4 4 666666 11111111 22222222 33333333 0
0 0 4 4 000000 00000000 00000000 00000000 0
0 1 4 4 777777 44444444 55555555 66666666 0

//--- sources.f
+incdir+hdl
hdl/pe_pkg.sv
hdl/pe_sequencer.sv
hdl/weight_buffer.sv
hdl/feature_window.sv
hdl/outer_product_array.sv
hdl/pe_unit.sv
bench/pe_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the pe_unit testbench with Verilator, run it and search the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f sources.f --top-module pe_unit_tb -o pe_unit_sim \
    && ./obj_dir/pe_unit_sim > sim.log 2>&1

grep -q "^Finished with no errors$" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
